//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // primary opcodes of the decoded subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // decode continues on funct
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        F_SLL     = 6'h00,
        F_SRL     = 6'h02,
        F_SRA     = 6'h03,
        F_SLLV    = 6'h04,
        F_SRLV    = 6'h06,
        F_SRAV    = 6'h07,
        F_JR      = 6'h08,
        F_JALR    = 6'h09,
        F_SYSCALL = 6'h0c,
        F_BREAK   = 6'h0d,
        F_ADD     = 6'h20,
        F_ADDU    = 6'h21,
        F_SUB     = 6'h22,
        F_SUBU    = 6'h23,
        F_AND     = 6'h24,
        F_OR      = 6'h25,
        F_XOR     = 6'h26,
        F_NOR     = 6'h27,
        F_SLT     = 6'h2a,
        F_SLTU    = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_NONE
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR, BR_JALR
    } br_kind_t;

    typedef enum logic [1:0] {SRC1_RS, SRC1_SA, SRC1_PC} src1_sel_t;
    typedef enum logic [1:0] {SRC2_RT, SRC2_IMM, SRC2_8} src2_sel_t;

    // cp0 cause codes seen by decode
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_TLBL = 5'd2,   // from fetch
        EXC_ADEL = 5'd4,   // from fetch
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10
    } exc_code_t;

endpackage

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // fetch to decode, 71 bits
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0] pc;
        logic [isa_pkg::XLEN-1:0] inst;
        logic                     bd;        // in a delay slot
        logic                     ex;
        isa_pkg::exc_code_t       exc_code;
    } fetch_bus_t;

    // register write from wb, 38 bits
    typedef struct packed {
        logic                       we;
        logic [isa_pkg::REG_AW-1:0] addr;
        logic [isa_pkg::XLEN-1:0]   data;
    } wb_bus_t;

    // one later stage as a forwarding source
    typedef struct packed {
        logic [isa_pkg::REG_AW-1:0] dest;    // 0 when nothing is written
        logic                       is_load; // result not ready yet
        logic [isa_pkg::XLEN-1:0]   result;
    } fwd_src_t;

    typedef struct packed {
        isa_pkg::alu_op_t           alu_op;
        isa_pkg::br_kind_t          br_kind;
        isa_pkg::src1_sel_t         src1_sel;
        isa_pkg::src2_sel_t         src2_sel;
        logic                       gr_we;
        logic                       mem_we;
        logic                       load_op;
        logic                       overflow_chk;  // add, addi, sub
        logic [isa_pkg::REG_AW-1:0] dest;
        logic [isa_pkg::XLEN-1:0]   imm_value;
        logic [isa_pkg::XLEN-1:0]   br_target;
        logic                       uses_rs;
        logic                       uses_rt;
        logic                       defined;
        logic                       is_syscall;
        logic                       is_break;
    } ctrl_t;

    // decode to execute, 187 bits
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]   pc;
        logic                       bd;
        logic                       ex;
        isa_pkg::exc_code_t         exc_code;
        isa_pkg::alu_op_t           alu_op;
        isa_pkg::br_kind_t          br_kind;
        isa_pkg::src1_sel_t         src1_sel;
        isa_pkg::src2_sel_t         src2_sel;
        logic                       gr_we;
        logic                       mem_we;
        logic                       load_op;
        logic                       overflow_chk;
        logic [isa_pkg::REG_AW-1:0] dest;
        logic [isa_pkg::XLEN-1:0]   rs_value;
        logic [isa_pkg::XLEN-1:0]   rt_value;
        logic [isa_pkg::XLEN-1:0]   imm_value;
        logic [isa_pkg::XLEN-1:0]   br_target;
    } decode_bus_t;

endpackage

`default_nettype wire

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire logic [isa_pkg::XLEN-1:0] inst,
    input  wire logic [isa_pkg::XLEN-1:0] pc,
    output pipe_pkg::ctrl_t               ctrl
);

    isa_pkg::opcode_t           op;
    isa_pkg::funct_t            fn;
    logic [isa_pkg::REG_AW-1:0] rs;
    logic [isa_pkg::REG_AW-1:0] rt;
    logic [isa_pkg::REG_AW-1:0] rd;
    logic [isa_pkg::REG_AW-1:0] sa;
    logic [isa_pkg::XLEN-1:0]   imm_sext;
    logic [isa_pkg::XLEN-1:0]   pc_plus4;

    assign op       = isa_pkg::opcode_t'(inst[31:26]);
    assign fn       = isa_pkg::funct_t'(inst[5:0]);
    assign rs       = inst[25:21];
    assign rt       = inst[20:16];
    assign rd       = inst[15:11];
    assign sa       = inst[10:6];
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign pc_plus4 = pc + 32'd4;

    // alu operation of a SPECIAL function code
    function automatic isa_pkg::alu_op_t funct_alu(input isa_pkg::funct_t f);
        case (f)
            isa_pkg::F_ADD, isa_pkg::F_ADDU:  return isa_pkg::ALU_ADD;
            isa_pkg::F_SUB, isa_pkg::F_SUBU:  return isa_pkg::ALU_SUB;
            isa_pkg::F_SLT:                   return isa_pkg::ALU_SLT;
            isa_pkg::F_SLTU:                  return isa_pkg::ALU_SLTU;
            isa_pkg::F_AND:                   return isa_pkg::ALU_AND;
            isa_pkg::F_OR:                    return isa_pkg::ALU_OR;
            isa_pkg::F_XOR:                   return isa_pkg::ALU_XOR;
            isa_pkg::F_NOR:                   return isa_pkg::ALU_NOR;
            isa_pkg::F_SLL, isa_pkg::F_SLLV:  return isa_pkg::ALU_SLL;
            isa_pkg::F_SRL, isa_pkg::F_SRLV:  return isa_pkg::ALU_SRL;
            isa_pkg::F_SRA, isa_pkg::F_SRAV:  return isa_pkg::ALU_SRA;
            default:                          return isa_pkg::ALU_NONE;
        endcase
    endfunction

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = isa_pkg::ALU_NONE;
        ctrl.br_kind   = isa_pkg::BR_NONE;
        ctrl.src1_sel  = isa_pkg::SRC1_RS;
        ctrl.src2_sel  = isa_pkg::SRC2_RT;
        ctrl.imm_value = imm_sext;
        ctrl.defined   = 1'b1;
        case (op)
            isa_pkg::OP_SPECIAL: begin
                case (fn)
                    isa_pkg::F_SLL, isa_pkg::F_SRL, isa_pkg::F_SRA: begin
                        ctrl.defined   = (rs == '0);
                        ctrl.alu_op    = funct_alu(fn);
                        ctrl.src1_sel  = isa_pkg::SRC1_SA;
                        ctrl.imm_value = {27'b0, sa};  // shift amount rides in imm
                        ctrl.gr_we     = 1'b1;
                        ctrl.dest      = rd;
                        ctrl.uses_rt   = 1'b1;
                    end
                    isa_pkg::F_JR: begin
                        ctrl.defined = (rt == '0) && (rd == '0) && (sa == '0);
                        ctrl.br_kind = isa_pkg::BR_JR;
                        ctrl.uses_rs = 1'b1;
                    end
                    isa_pkg::F_JALR: begin
                        ctrl.defined  = (rt == '0) && (sa == '0);
                        ctrl.br_kind  = isa_pkg::BR_JALR;
                        ctrl.alu_op   = isa_pkg::ALU_ADD;   // link = pc + 8
                        ctrl.src1_sel = isa_pkg::SRC1_PC;
                        ctrl.src2_sel = isa_pkg::SRC2_8;
                        ctrl.gr_we    = 1'b1;
                        ctrl.dest     = rd;
                        ctrl.uses_rs  = 1'b1;
                    end
                    isa_pkg::F_SYSCALL: ctrl.is_syscall = 1'b1;
                    isa_pkg::F_BREAK:   ctrl.is_break   = 1'b1;
                    default: begin
                        // register-register alu ops, sa must be zero
                        ctrl.defined      = (funct_alu(fn) != isa_pkg::ALU_NONE) && (sa == '0);
                        ctrl.alu_op       = funct_alu(fn);
                        ctrl.overflow_chk = (fn == isa_pkg::F_ADD) || (fn == isa_pkg::F_SUB);
                        ctrl.gr_we        = 1'b1;
                        ctrl.dest         = rd;
                        ctrl.uses_rs      = 1'b1;
                        ctrl.uses_rt      = 1'b1;
                    end
                endcase
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU,
            isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI: begin
                ctrl.src2_sel = isa_pkg::SRC2_IMM;
                ctrl.gr_we    = 1'b1;
                ctrl.dest     = rt;
                ctrl.uses_rs  = (op != isa_pkg::OP_LUI);
                case (op)
                    isa_pkg::OP_SLTI:  ctrl.alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::OP_SLTIU: ctrl.alu_op = isa_pkg::ALU_SLTU;
                    isa_pkg::OP_ANDI:  ctrl.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::OP_ORI:   ctrl.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::OP_XORI:  ctrl.alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::OP_LUI:   ctrl.alu_op = isa_pkg::ALU_LUI;
                    default:           ctrl.alu_op = isa_pkg::ALU_ADD;
                endcase
                ctrl.overflow_chk = (op == isa_pkg::OP_ADDI);
                if (op inside {isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI,
                               isa_pkg::OP_LUI}) begin
                    ctrl.imm_value = {16'b0, inst[15:0]};  // lui shifted up in exe
                end
            end
            isa_pkg::OP_LW, isa_pkg::OP_SW: begin
                ctrl.alu_op   = isa_pkg::ALU_ADD;   // address = rs + offset
                ctrl.src2_sel = isa_pkg::SRC2_IMM;
                ctrl.uses_rs  = 1'b1;
                ctrl.load_op  = (op == isa_pkg::OP_LW);
                ctrl.gr_we    = (op == isa_pkg::OP_LW);
                ctrl.mem_we   = (op == isa_pkg::OP_SW);
                ctrl.uses_rt  = (op == isa_pkg::OP_SW);
                ctrl.dest     = (op == isa_pkg::OP_LW) ? rt : '0;
            end
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                ctrl.br_kind   = (op == isa_pkg::OP_BEQ) ? isa_pkg::BR_BEQ : isa_pkg::BR_BNE;
                ctrl.br_target = pc_plus4 + {imm_sext[29:0], 2'b00};
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
            end
            isa_pkg::OP_J, isa_pkg::OP_JAL: begin
                ctrl.br_target = {pc_plus4[31:28], inst[25:0], 2'b00};
                ctrl.br_kind   = (op == isa_pkg::OP_J) ? isa_pkg::BR_J : isa_pkg::BR_JAL;
                if (op == isa_pkg::OP_JAL) begin
                    ctrl.alu_op   = isa_pkg::ALU_ADD;
                    ctrl.src1_sel = isa_pkg::SRC1_PC;
                    ctrl.src2_sel = isa_pkg::SRC2_8;
                    ctrl.gr_we    = 1'b1;
                    ctrl.dest     = 5'd31;
                end
            end
            default: ctrl.defined = 1'b0;  // raises RI
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [isa_pkg::REG_AW-1:0] raddr1,
    input  wire logic [isa_pkg::REG_AW-1:0] raddr2,
    input  wire pipe_pkg::wb_bus_t          wr,
    output logic [isa_pkg::XLEN-1:0]        rdata1,
    output logic [isa_pkg::XLEN-1:0]        rdata2
);

    logic [isa_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.addr != '0) begin  // r0 is hardwired
            regs[wr.addr] <= wr.data;
        end
    end

    // asynchronous reads, same-cycle write covered by wb forwarding
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_r0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

//--- hdl/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward #(
    parameter int FWD_STAGES = 3
) (
    input  wire logic                                valid,
    input  wire logic [isa_pkg::REG_AW-1:0]          rs,
    input  wire logic [isa_pkg::REG_AW-1:0]          rt,
    input  wire logic                                uses_rs,
    input  wire logic                                uses_rt,
    input  wire logic [isa_pkg::XLEN-1:0]            rf_rs,
    input  wire logic [isa_pkg::XLEN-1:0]            rf_rt,
    input  wire pipe_pkg::fwd_src_t [FWD_STAGES-1:0] fwd,
    output logic [isa_pkg::XLEN-1:0]                 rs_value,
    output logic [isa_pkg::XLEN-1:0]                 rt_value,
    output logic                                     stall
);

    typedef struct packed {
        logic                     hit;
        logic                     load;
        logic [isa_pkg::XLEN-1:0] value;
    } pick_t;

    pick_t rs_pick;
    pick_t rt_pick;
    logic  any_match;

    // nearest matching stage wins, so walk from the farthest one down
    function automatic pick_t pick(input logic [isa_pkg::REG_AW-1:0]          r,
                                   input logic                                used,
                                   input logic [isa_pkg::XLEN-1:0]            rf_data,
                                   input pipe_pkg::fwd_src_t [FWD_STAGES-1:0] src);
        pick_t p;
        p = '{hit: 1'b0, load: 1'b0, value: rf_data};
        for (int i = FWD_STAGES - 1; i >= 0; i--) begin
            if (used && r != '0 && src[i].dest == r) begin
                p = '{hit: 1'b1, load: src[i].is_load, value: src[i].result};
            end
        end
        return p;
    endfunction

    assign rs_pick  = pick(rs, uses_rs, rf_rs, fwd);
    assign rt_pick  = pick(rt, uses_rt, rf_rt, fwd);
    assign rs_value = rs_pick.value;
    assign rt_value = rt_pick.value;
    assign stall    = valid && ((rs_pick.hit && rs_pick.load) || (rt_pick.hit && rt_pick.load));

    // raw match of any writing stage against either source
    always_comb begin
        any_match = 1'b0;
        for (int i = 0; i < FWD_STAGES; i++) begin
            if (fwd[i].dest != '0 && (fwd[i].dest == rs || fwd[i].dest == rt)) begin
                any_match = 1'b1;
            end
        end
    end

    always_comb begin
        a_stall_has_source: assert final (!stall || any_match);
    end

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
    parameter int FWD_STAGES = 3
) (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                flush,
    input  wire logic                                fs_to_ds_valid,
    input  wire pipe_pkg::fetch_bus_t                fs_to_ds_bus,
    output logic                                     ds_allowin,
    input  wire logic                                es_allowin,
    output logic                                     ds_to_es_valid,
    output pipe_pkg::decode_bus_t                    ds_to_es_bus,
    input  wire pipe_pkg::wb_bus_t                   ws_to_rf_bus,
    input  wire pipe_pkg::fwd_src_t [FWD_STAGES-1:0] fwd,
    output logic                                     is_branch
);

    logic                       ds_valid;
    pipe_pkg::fetch_bus_t       fs_r;       // instruction held in decode
    pipe_pkg::ctrl_t            ctrl;
    logic [isa_pkg::REG_AW-1:0] rs;
    logic [isa_pkg::REG_AW-1:0] rt;
    logic [isa_pkg::XLEN-1:0]   rf_rs;
    logic [isa_pkg::XLEN-1:0]   rf_rt;
    logic [isa_pkg::XLEN-1:0]   rs_value;
    logic [isa_pkg::XLEN-1:0]   rt_value;
    logic                       stall;

    assign rs = fs_r.inst[25:21];
    assign rt = fs_r.inst[20:16];

    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_r <= fs_to_ds_bus;
        end
    end

    inst_decoder i_inst_decoder (
        .inst (fs_r.inst),
        .pc   (fs_r.pc),
        .ctrl (ctrl)
    );

    regfile i_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs),
        .raddr2 (rt),
        .wr     (ws_to_rf_bus),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    operand_forward #(
        .FWD_STAGES (FWD_STAGES)
    ) i_operand_forward (
        .valid    (ds_valid),
        .rs       (rs),
        .rt       (rt),
        .uses_rs  (ctrl.uses_rs),
        .uses_rt  (ctrl.uses_rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .fwd      (fwd),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .stall    (stall)
    );

    assign is_branch = ds_valid && (ctrl.br_kind != isa_pkg::BR_NONE);

    always_comb begin
        ds_to_es_bus              = '0;
        ds_to_es_bus.pc           = fs_r.pc;
        ds_to_es_bus.bd           = fs_r.bd;
        ds_to_es_bus.ex           = fs_r.ex || !ctrl.defined || ctrl.is_syscall
                                    || ctrl.is_break;
        // fetch fault keeps its own code
        ds_to_es_bus.exc_code     = fs_r.ex         ? fs_r.exc_code    :
                                    !ctrl.defined   ? isa_pkg::EXC_RI  :
                                    ctrl.is_syscall ? isa_pkg::EXC_SYS :
                                    ctrl.is_break   ? isa_pkg::EXC_BP  : isa_pkg::EXC_NONE;
        ds_to_es_bus.alu_op       = ctrl.alu_op;
        ds_to_es_bus.br_kind      = ctrl.br_kind;
        ds_to_es_bus.src1_sel     = ctrl.src1_sel;
        ds_to_es_bus.src2_sel     = ctrl.src2_sel;
        ds_to_es_bus.gr_we        = ctrl.gr_we;
        ds_to_es_bus.mem_we       = ctrl.mem_we;
        ds_to_es_bus.load_op      = ctrl.load_op;
        ds_to_es_bus.overflow_chk = ctrl.overflow_chk;
        ds_to_es_bus.dest         = ctrl.dest;
        ds_to_es_bus.rs_value     = rs_value;
        ds_to_es_bus.rt_value     = rt_value;
        ds_to_es_bus.imm_value    = ctrl.imm_value;
        ds_to_es_bus.br_target    = ctrl.br_target;
    end

    a_valid_out: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid |-> ds_valid);

    // held instruction survives back-pressure and stalls
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (ds_valid && !ds_allowin) |=> $stable(fs_r));

endmodule

`default_nettype wire

//--- verification/id_stage_vectors.svh
// columns: inst, pc, fwd mode, cycles, kind, fetch code, then expected alu, br, sel, flags,
// dest, imm, target, exc code
// fwd mode 0 none, 1 all stages match rs, 2 wb matches rs, 3 exe load on rs, 4 dest r0
// kind 0 plain, 1 flush, 2 es back-pressure; sel {src1, src2}; flags {gr_we, mem_we, load, ovf}
task automatic build_table();
    add_row(32'h00221821, PC0, 0, 0, 0, 0, 0, 0, 'h00, 4'b1000, 3, 32'h00001821, 0, 0);
    add_row(32'h00221823, PC0, 0, 0, 0, 0, 1, 0, 'h00, 4'b1000, 3, 32'h00001823, 0, 0);
    add_row(32'h00221820, PC0, 0, 0, 0, 0, 0, 0, 'h00, 4'b1001, 3, 32'h00001820, 0, 0);
    add_row(32'h00221822, PC0, 0, 0, 0, 0, 1, 0, 'h00, 4'b1001, 3, 32'h00001822, 0, 0);
    add_row(32'h0022182a, PC0, 0, 0, 0, 0, 2, 0, 'h00, 4'b1000, 3, 32'h0000182a, 0, 0);
    add_row(32'h0022182b, PC0, 0, 0, 0, 0, 3, 0, 'h00, 4'b1000, 3, 32'h0000182b, 0, 0);
    add_row(32'h00221824, PC0, 0, 0, 0, 0, 4, 0, 'h00, 4'b1000, 3, 32'h00001824, 0, 0);
    add_row(32'h00221825, PC0, 0, 0, 0, 0, 5, 0, 'h00, 4'b1000, 3, 32'h00001825, 0, 0);
    add_row(32'h00221826, PC0, 0, 0, 0, 0, 6, 0, 'h00, 4'b1000, 3, 32'h00001826, 0, 0);
    add_row(32'h00221827, PC0, 0, 0, 0, 0, 7, 0, 'h00, 4'b1000, 3, 32'h00001827, 0, 0);
    add_row(32'h000520c0, PC0, 0, 0, 0, 0, 8, 0, 'h10, 4'b1000, 4, 32'h00000003, 0, 0);
    add_row(32'h000520c2, PC0, 0, 0, 0, 0, 9, 0, 'h10, 4'b1000, 4, 32'h00000003, 0, 0);
    add_row(32'h000520c3, PC0, 0, 0, 0, 0, 10, 0, 'h10, 4'b1000, 4, 32'h00000003, 0, 0);
    add_row(32'h00221804, PC0, 0, 0, 0, 0, 8, 0, 'h00, 4'b1000, 3, 32'h00001804, 0, 0);
    add_row(32'h00221806, PC0, 0, 0, 0, 0, 9, 0, 'h00, 4'b1000, 3, 32'h00001806, 0, 0);
    add_row(32'h00221807, PC0, 0, 0, 0, 0, 10, 0, 'h00, 4'b1000, 3, 32'h00001807, 0, 0);
    add_row(32'h2482ffff, PC0, 0, 0, 0, 0, 0, 0, 'h01, 4'b1000, 2, 32'hffffffff, 0, 0);
    add_row(32'h2082ffff, PC0, 0, 0, 0, 0, 0, 0, 'h01, 4'b1001, 2, 32'hffffffff, 0, 0);
    add_row(32'h2882ffff, PC0, 0, 0, 0, 0, 2, 0, 'h01, 4'b1000, 2, 32'hffffffff, 0, 0);
    add_row(32'h2c82ffff, PC0, 0, 0, 0, 0, 3, 0, 'h01, 4'b1000, 2, 32'hffffffff, 0, 0);
    add_row(32'h30a38001, PC0, 0, 0, 0, 0, 4, 0, 'h01, 4'b1000, 3, 32'h00008001, 0, 0);
    add_row(32'h34a38001, PC0, 0, 0, 0, 0, 5, 0, 'h01, 4'b1000, 3, 32'h00008001, 0, 0);
    add_row(32'h38a38001, PC0, 0, 0, 0, 0, 6, 0, 'h01, 4'b1000, 3, 32'h00008001, 0, 0);
    add_row(32'h3c07beef, PC0, 0, 0, 0, 0, 11, 0, 'h01, 4'b1000, 7, 32'h0000beef, 0, 0);
    add_row(32'h8ce60008, PC0, 0, 0, 0, 0, 0, 0, 'h01, 4'b1010, 6, 32'h00000008, 0, 0);
    add_row(32'had09fffc, PC0, 0, 0, 0, 0, 0, 0, 'h01, 4'b0100, 0, 32'hfffffffc, 0, 0);
    add_row(32'h10220004, PC0, 0, 0, 0, 0, 12, 1, 'h00, 4'b0000, 0, 32'h4, 32'h00400114, 0);
    add_row(32'h1422ffff, PC0, 0, 0, 0, 0, 12, 2, 'h00, 4'b0000, 0, '1, 32'h00400100, 0);
    add_row(32'h08100040, PC0, 0, 0, 0, 0, 12, 3, 'h00, 4'b0000, 0, 32'h40, 32'h00400100, 0);
    add_row(32'h0c100040, PC0, 0, 0, 0, 0, 0, 4, 'h22, 4'b1000, 31, 32'h40, 32'h00400100, 0);
    add_row(32'h03e00008, PC0, 0, 0, 0, 0, 12, 5, 'h00, 4'b0000, 0, 32'h8, 0, 0);
    add_row(32'h00a0f809, PC0, 0, 0, 0, 0, 0, 6, 'h22, 4'b1000, 31, 32'hfffff809, 0, 0);
    add_row(32'h0000000c, PC0, 0, 0, 0, 0, 12, 0, 'h00, 4'b0000, 0, 32'hc, 0, 8);
    add_row(32'h0000000d, PC0, 0, 0, 0, 0, 12, 0, 'h00, 4'b0000, 0, 32'hd, 0, 9);
    add_row(32'hfc000000, PC0, 0, 0, 0, 0, 12, 0, 'h00, 4'b0000, 0, 32'h0, 0, 10);
    add_row(32'hfc000000, PC0, 0, 0, 0, 4, 12, 0, 'h00, 4'b0000, 0, 32'h0, 0, 4);
    add_row(32'h00221821, PC0, 1, 0, 0, 0, 0, 0, 'h00, 4'b1000, 3, 32'h00001821, 0, 0);
    add_row(32'h00221821, PC0, 2, 0, 0, 0, 0, 0, 'h00, 4'b1000, 3, 32'h00001821, 0, 0);
    add_row(32'h00021825, PC0, 4, 0, 0, 0, 5, 0, 'h00, 4'b1000, 3, 32'h00001825, 0, 0);
    add_row(32'h00221821, PC0, 3, 3, 0, 0, 0, 0, 'h00, 4'b1000, 3, 32'h00001821, 0, 0);
    add_row(32'h00221821, PC0, 0, 4, 2, 0, 0, 0, 'h00, 4'b1000, 3, 32'h00001821, 0, 0);
    add_row(32'h00221821, PC0, 0, 0, 1, 0, 0, 0, 'h00, 4'b1000, 3, 32'h00001821, 0, 0);
endtask

//--- verification/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;

    localparam int FWD_STAGES = 3;
    localparam logic [31:0] PC0 = 32'h0040_0100;

    typedef pipe_pkg::fwd_src_t [FWD_STAGES-1:0] fwd_vec_t;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        int          mode;
        int          cycles;
        int          kind;
        logic [4:0]  fcode;
        logic [3:0]  alu;
        logic [2:0]  br;
        logic [7:0]  sel;
        logic [3:0]  flags;
        logic [4:0]  dest;
        logic [31:0] imm;
        logic [31:0] target;
        logic [4:0]  exc;
    } row_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  flush;
    logic                  fs_to_ds_valid;
    pipe_pkg::fetch_bus_t  fs_to_ds_bus;
    logic                  ds_allowin;
    logic                  es_allowin;
    logic                  ds_to_es_valid;
    pipe_pkg::decode_bus_t ds_to_es_bus;
    pipe_pkg::wb_bus_t     ws_to_rf_bus;
    fwd_vec_t              fwd;
    logic                  is_branch;

    logic [31:0] model [32];   // expected register contents
    logic [31:0] lfsr = 32'h35eb_f2c0;
    row_t        rows [$];
    int          cycles = 0;
    int          limit = 0;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout: the DUT did not finish the table within %0d cycles", limit);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    id_stage #(.FWD_STAGES(FWD_STAGES)) i_id_stage (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ws_to_rf_bus   (ws_to_rf_bus),
        .fwd            (fwd),
        .is_branch      (is_branch)
    );

    task automatic add_row(input logic [31:0] inst, input logic [31:0] pc, input int mode,
                           input int cyc, input int kind, input int fcode, input int alu,
                           input int br, input logic [7:0] sel, input logic [3:0] flags,
                           input int dest, input logic [31:0] imm, input logic [31:0] target,
                           input int exc);
        rows.push_back('{inst, pc, mode, cyc, kind, fcode[4:0], alu[3:0], br[2:0], sel, flags,
                         dest[4:0], imm, target, exc[4:0]});
    endtask

    `include "id_stage_vectors.svh"

    // one galois step per bit taken
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] next_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            w[i] = next_bit();
        end
        return w;
    endfunction

    function automatic fwd_vec_t build_fwd(input int mode, input logic [4:0] rs);
        fwd_vec_t f;
        f = '0;
        f[0].result = 32'he0e0_0001;
        f[1].result = 32'ha0a0_0002;
        f[2].result = 32'hb0b0_0003;
        case (mode)
            1: begin
                f[0].dest = rs;
                f[1].dest = rs;
                f[2].dest = rs;
            end
            2: f[2].dest = rs;
            3: begin
                f[0].dest    = rs;
                f[0].is_load = 1'b1;
            end
            default: ;   // mode 4 keeps every dest at r0
        endcase
        return f;
    endfunction

    // nearest stage with a matching nonzero dest, else the register model
    function automatic logic [31:0] source_value(input logic [4:0] r, input fwd_vec_t f);
        for (int i = 0; i < FWD_STAGES; i++) begin
            if (r != 0 && f[i].dest == r) begin
                return f[i].result;
            end
        end
        return model[r];
    endfunction

    function automatic pipe_pkg::decode_bus_t expected_bus(input row_t r, input fwd_vec_t f,
                                                           input logic bd);
        pipe_pkg::decode_bus_t b;
        b              = '0;
        b.pc           = r.pc;
        b.bd           = bd;
        b.ex           = (r.exc != 0);
        b.exc_code     = isa_pkg::exc_code_t'(r.exc);
        b.alu_op       = isa_pkg::alu_op_t'(r.alu);
        b.br_kind      = isa_pkg::br_kind_t'(r.br);
        b.src1_sel     = isa_pkg::src1_sel_t'(r.sel[5:4]);
        b.src2_sel     = isa_pkg::src2_sel_t'(r.sel[1:0]);
        {b.gr_we, b.mem_we, b.load_op, b.overflow_chk} = r.flags;
        b.dest         = r.dest;
        b.rs_value     = source_value(r.inst[25:21], f);
        b.rt_value     = model[r.inst[20:16]];   // rows never forward rt
        b.imm_value    = r.imm;
        b.br_target    = r.target;
        return b;
    endfunction

    task automatic fail_now();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_bus(input string name, input pipe_pkg::decode_bus_t exp,
                             input pipe_pkg::decode_bus_t got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
            fail_now();
        end
    endtask

    task automatic check_exc(input string name, input isa_pkg::exc_code_t exp,
                             input isa_pkg::exc_code_t got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %s, got %s", $time, name, exp.name(),
                     got.name());
            fail_now();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_output(input pipe_pkg::decode_bus_t exp);
        check_bit("ds_to_es_valid", 1'b1, ds_to_es_valid);
        check_exc("ds_to_es_bus.exc_code", exp.exc_code, ds_to_es_bus.exc_code);
        check_bus("ds_to_es_bus", exp, ds_to_es_bus);
        check_bit("is_branch", exp.br_kind != isa_pkg::BR_NONE, is_branch);
    endtask

    initial begin
        row_t                  r;
        pipe_pkg::decode_bus_t exp;
        logic                  in_slot;
        reset          = 1'b1;
        flush          = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_to_rf_bus   = '0;
        fwd            = '0;
        model[0]       = '0;
        in_slot        = 1'b0;
        build_table();
        limit = rows.size() * 40 + 31 + 16 + 8;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 1; i < 32; i++) begin
            model[i]     = next_word();
            ws_to_rf_bus = '{we: 1'b1, addr: i[4:0], data: model[i]};
            step();
        end
        ws_to_rf_bus = '0;
        foreach (rows[n]) begin
            r = rows[n];
            fwd = build_fwd(r.mode, r.inst[25:21]);
            exp = expected_bus(r, fwd, in_slot);
            fs_to_ds_bus = '{pc: r.pc, inst: r.inst, bd: in_slot, ex: (r.fcode != 0),
                             exc_code: isa_pkg::exc_code_t'(r.fcode)};
            fs_to_ds_valid = 1'b1;
            do @(negedge clk); while (!ds_allowin);
            step();
            fs_to_ds_valid    = (r.kind == 2);   // a new word waits during back-pressure
            fs_to_ds_bus.inst = ~r.inst;
            flush             = (r.kind == 1);
            es_allowin        = (r.kind != 2);
            if (r.mode == 3) begin
                for (int k = 0; k < r.cycles; k++) begin
                    @(negedge clk);
                    check_bit("ds_to_es_valid", 1'b0, ds_to_es_valid);
                    check_bit("ds_allowin", 1'b0, ds_allowin);
                    step();
                end
                fwd[0].is_load = 1'b0;   // load data now available
            end
            @(negedge clk);
            check_output(exp);
            if (r.kind == 2) begin
                for (int k = 0; k < r.cycles; k++) begin
                    check_bit("ds_allowin", 1'b0, ds_allowin);
                    step();
                    @(negedge clk);
                    check_output(exp);
                end
                step();
                es_allowin     = 1'b1;
                fs_to_ds_valid = 1'b0;
                @(negedge clk);
                check_output(exp);
            end else if (r.kind == 1) begin
                step();
                flush = 1'b0;
                @(negedge clk);
                check_bit("ds_to_es_valid", 1'b0, ds_to_es_valid);
            end
            step();
            fwd     = '0;
            in_slot = (isa_pkg::br_kind_t'(r.br) != isa_pkg::BR_NONE);  // next row in delay slot
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/operand_forward.sv
hdl/id_stage.sv
+incdir+verification
verification/id_stage_tb.sv
